/* cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_controller
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      addr,
    input  word_t      data_in,
    input  logic       rd,
    input  logic       wr,
    input  logic       hit_final,
    input  logic       fill_way,
    input  logic       victim_dirty,
    input  tag_t       tag_out_final,
    input  word_t      word_out_final,
    input  word_t      mem_rdata,
    output logic [1:0] way_en,
    output index_t     index,
    output offset_t    offset,
    output tag_t       tag_in,
    output word_t      word_in,
    output logic       comp,
    output logic       write,
    output logic       valid_in,
    output logic       sel_way,
    output logic       flip_victim,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    output logic       write_mem,
    output logic       read_mem,
    output word_t      data_out,
    output logic       done,
    output logic       stall,
    output logic       cache_hit
);

    ctrl_state_t             state;
    ctrl_state_t             nxt_state;
    logic                    req_wr;          // request kind, taken when idle accepts it.
    logic                    fill_way_q;
    logic                    victim_dirty_q;
    word_t                   data_q;
    logic                    capture;         // the requested word is on mem_rdata.
    tag_t                    req_tag;
    index_t                  req_index;
    logic [`CACHE_OFS_W-2:0] req_word;
    logic [`CACHE_OFS_W-2:0] mem_word;        // word on the memory port this cycle.
    logic [`CACHE_OFS_W-2:0] fill_word;       // word written into the way this cycle.
    logic [1:0]              fill_en;

    assign req_tag   = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index = addr[`CACHE_OFS_W +: `CACHE_IDX_W];
    assign req_word  = addr[`CACHE_OFS_W-1:1];
    assign fill_en   = fill_way_q ? 2'b10 : 2'b01;
    assign sel_way   = fill_way_q;

    // Memory reads run two states ahead of the way writes.
    always_comb begin
        case (state)
            wb_1, fill_1: mem_word = 2'd1;
            wb_2, fill_2: mem_word = 2'd2;
            wb_3, fill_3: mem_word = 2'd3;
            default:      mem_word = 2'd0;
        endcase
        case (state)
            fill_3:  fill_word = 2'd1;
            fill_4:  fill_word = 2'd2;
            fill_5:  fill_word = 2'd3;
            default: fill_word = 2'd0;
        endcase
    end

    always_comb begin
        nxt_state   = state;
        way_en      = 2'b00;
        index       = req_index;
        offset      = addr[`CACHE_OFS_W-1:0];
        tag_in      = req_tag;
        word_in     = data_in;
        comp        = 1'b0;
        write       = 1'b0;
        valid_in    = 1'b0;
        flip_victim = 1'b0;
        mem_addr    = {addr[`CACHE_ADDR_W-1:`CACHE_OFS_W], mem_word, 1'b0};
        mem_wdata   = word_out_final;
        write_mem   = 1'b0;
        read_mem    = 1'b0;
        done        = 1'b0;
        stall       = 1'b1;
        cache_hit   = 1'b0;
        capture     = 1'b0;
        case (state)
            idle: begin
                stall = 1'b0;
                if (rd) begin
                    nxt_state = comp_rd;
                end else if (wr) begin
                    nxt_state = comp_wr;
                end
            end
            comp_rd, comp_wr: begin
                way_en    = 2'b11;  // both ways look up the tag.
                comp      = 1'b1;
                write     = (state == comp_wr);
                done      = hit_final;
                cache_hit = hit_final;
                if (hit_final) begin
                    nxt_state = idle;
                end else if (victim_dirty) begin
                    nxt_state = wb_0;
                end else begin
                    nxt_state = fill_0;
                end
            end
            wb_0, wb_1, wb_2, wb_3: begin
                way_en    = fill_en;
                offset    = {mem_word, 1'b0};
                mem_addr  = {tag_out_final, req_index, mem_word, 1'b0};  // victim's address.
                write_mem = 1'b1;
                nxt_state = (state == wb_3) ? fill_0 : ctrl_state_t'(state + 1);
            end
            fill_0, fill_1, fill_2, fill_3, fill_4, fill_5: begin
                way_en   = fill_en;
                read_mem = (state inside {fill_0, fill_1, fill_2, fill_3});
                if (state inside {fill_2, fill_3, fill_4, fill_5}) begin
                    write    = 1'b1;
                    valid_in = 1'b1;
                    offset   = {fill_word, 1'b0};
                    word_in  = (req_wr && req_word == fill_word) ? data_in : mem_rdata;
                    capture  = !req_wr && (req_word == fill_word);
                end
                if (state == fill_5) begin
                    comp        = req_wr;  // the write hit on the last word marks the line dirty.
                    done        = 1'b1;
                    flip_victim = 1'b1;
                    nxt_state   = idle;
                end else begin
                    nxt_state = ctrl_state_t'(state + 1);
                end
            end
            default: begin
                nxt_state = idle;
            end
        endcase
    end

    // The read word is passed straight through in the cycle it appears.
    always_comb begin
        if (state == comp_rd) begin
            data_out = word_out_final;
        end else if (capture) begin
            data_out = mem_rdata;
        end else begin
            data_out = data_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state == comp_rd || capture) begin
            data_q <= data_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= idle;
            req_wr         <= 1'b0;
            fill_way_q     <= 1'b0;
            victim_dirty_q <= 1'b0;
        end else begin
            state <= nxt_state;
            if (state == idle) begin
                req_wr <= wr;
            end
            if (state == comp_rd || state == comp_wr) begin
                fill_way_q     <= fill_way;
                victim_dirty_q <= victim_dirty;
            end
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd && wr));

    a_addr_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd || wr) |-> !addr[0]
    );

    // done only ends a request that was already under way, or hits in compare.
    a_done_ctx: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> $past(stall) || (state inside {comp_rd, comp_wr})
    );

    // The chosen way keeps the dirty state that compare latched until the write-back ends.
    a_wb_dirty: assert property (
        @(posedge clk) disable iff (!rst_n)
        write_mem |-> (victim_dirty == victim_dirty_q)
    );

endmodule

`default_nettype wire

/* cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// processor side.
`define CACHE_ADDR_W 16  // byte address.
`define CACHE_DATA_W 16  // one word.

// address split is tag, index, byte offset from the top down.
`define CACHE_TAG_W 5
`define CACHE_IDX_W 8    // 256 sets.
`define CACHE_OFS_W 3

// a line holds four words.
`define CACHE_WORDS 4

// cycles from read_mem to data on mem_rdata.
`define MEM_READ_LAT 2

`endif

/* cache_pkg.sv */
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_DATA_W-1:0] word_t;
    typedef logic [`CACHE_TAG_W-1:0]  tag_t;     // addr[15:11].
    typedef logic [`CACHE_IDX_W-1:0]  index_t;   // addr[10:3].
    typedef logic [`CACHE_OFS_W-1:0]  offset_t;  // bit 0 is always zero.

    // wb states write the victim back, fill states refill the line.
    typedef enum logic [3:0] {
        idle,
        comp_rd,
        comp_wr,
        wb_0,
        wb_1,
        wb_2,
        wb_3,
        fill_0,
        fill_1,
        fill_2,
        fill_3,
        fill_4,
        fill_5
    } ctrl_state_t;

endpackage

`default_nettype wire

/* cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_tb
    import cache_pkg::*;
;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    word_t data_in;
    logic  rd;
    logic  wr;
    word_t data_out;
    logic  done;
    logic  stall;
    logic  cache_hit;

    logic [31:0] lfsr_q;
    word_t       mem_m   [1 << (`CACHE_ADDR_W - 1)];  // last value written to each word.
    tag_t        tag_m   [2][1 << `CACHE_IDX_W];
    logic        valid_m [2][1 << `CACHE_IDX_W];
    logic        victim_m;

    cache_top dut (
        .clk, .rst_n, .addr, .data_in, .rd, .wr,
        .data_out, .done, .stall, .cache_hit
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha3000000;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic addr_t make_addr(input tag_t t, input index_t x, input logic [1:0] w);
        return {t, x, w, 1'b0};
    endfunction

    function automatic logic predict_hit(input addr_t a);
        tag_t   t;
        index_t x;
        t = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        x = a[`CACHE_OFS_W +: `CACHE_IDX_W];
        return (valid_m[0][x] && tag_m[0][x] == t) || (valid_m[1][x] && tag_m[1][x] == t);
    endfunction

    function automatic word_t expect_word(input addr_t a);
        return mem_m[a[`CACHE_ADDR_W-1:1]];
    endfunction

    // empty ways first, then the shared victim bit.
    function automatic logic model_fill_way(input index_t x);
        if (!valid_m[0][x]) begin
            return 1'b0;
        end else if (!valid_m[1][x]) begin
            return 1'b1;
        end
        return victim_m;
    endfunction

    task automatic model_update(input addr_t a, input logic is_wr, input word_t d);
        index_t x;
        logic   w;
        x = a[`CACHE_OFS_W +: `CACHE_IDX_W];
        if (!predict_hit(a)) begin
            w             = model_fill_way(x);
            tag_m[w][x]   = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
            valid_m[w][x] = 1'b1;
            victim_m      = ~victim_m;  // every fill flips it.
        end
        if (is_wr) begin
            mem_m[a[`CACHE_ADDR_W-1:1]] = d;
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic run_req(input addr_t a, input logic is_wr, input word_t d);
        logic  exp_hit;
        word_t exp_data;
        logic  seen;
        int    cycles;
        exp_hit  = predict_hit(a);
        exp_data = expect_word(a);
        seen     = 1'b0;
        cycles   = 0;
        @(negedge clk);
        addr    = a;
        data_in = d;
        rd      = !is_wr;
        wr      = is_wr;
        while (!seen && cycles < 20) begin
            @(negedge clk);
            cycles++;
            check_flag(stall, 1'b1, "stall while busy");
            if (done) begin
                seen = 1'b1;
                check_flag(cache_hit, exp_hit, "cache_hit");
                if (!is_wr) begin
                    check_word(data_out, exp_data, "data_out");
                end
            end
        end
        if (!seen) begin
            $display("done never arrived for the request to address %h at %0t", a, $time);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        rd = 1'b0;  // addr and data_in stay put until the next request.
        wr = 1'b0;
        model_update(a, is_wr, d);
    endtask

    initial begin
        addr_t       a_addr;
        addr_t       b_addr;
        addr_t       c_addr;
        addr_t       line;
        logic [31:0] r_tag;
        logic [31:0] r_idx;
        logic [31:0] r_word;
        logic [31:0] r_op;
        logic [31:0] r_data;
        clk      = 1'b0;
        rst_n    = 1'b0;
        addr     = '0;
        data_in  = '0;
        rd       = 1'b0;
        wr       = 1'b0;
        lfsr_q   = 32'h0a94fd66;
        victim_m = 1'b0;
        for (int w = 0; w < 2; w++) begin
            for (int x = 0; x < (1 << `CACHE_IDX_W); x++) begin
                valid_m[w][x] = 1'b0;
                tag_m[w][x]   = '0;
            end
        end
        for (int i = 0; i < (1 << (`CACHE_ADDR_W - 1)); i++) begin
            mem_m[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(stall, 1'b0, "stall after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(cache_hit, 1'b0, "cache_hit after reset");
        run_req(16'h1234, 1'b0, '0);

        line = make_addr(5'h03, 8'h21, 2'd0);
        run_req(line | 16'h4, 1'b0, '0);
        for (int w = 0; w < 4; w++) begin
            run_req(make_addr(5'h03, 8'h21, w[1:0]), 1'b0, '0);
        end

        run_req(make_addr(5'h07, 8'h42, 2'd1), 1'b1, 16'h1234);
        run_req(make_addr(5'h07, 8'h42, 2'd3), 1'b1, 16'hbeef);
        run_req(make_addr(5'h07, 8'h42, 2'd1), 1'b0, '0);
        run_req(make_addr(5'h07, 8'h42, 2'd3), 1'b0, '0);
        run_req(make_addr(5'h07, 8'h42, 2'd0), 1'b0, '0);

        a_addr = make_addr(5'h01, 8'h85, 2'd2);
        b_addr = make_addr(5'h02, 8'h85, 2'd0);
        c_addr = make_addr(5'h03, 8'h85, 2'd1);
        run_req(a_addr, 1'b1, 16'ha5a5);
        run_req(b_addr, 1'b1, 16'h5a5a);
        // one extra fill elsewhere points the victim bit at the first tag's way.
        if (model_fill_way(8'h85) != 1'b0) begin
            run_req(make_addr(5'h1f, 8'hee, 2'd0), 1'b0, '0);
        end
        run_req(c_addr, 1'b1, 16'hc3c3);
        run_req(a_addr, 1'b0, '0);
        run_req(b_addr, 1'b0, '0);
        run_req(c_addr, 1'b0, '0);

        for (int i = 0; i < 300; i++) begin
            take_bits(2, r_tag);
            take_bits(2, r_idx);
            take_bits(2, r_word);
            take_bits(1, r_op);
            take_bits(16, r_data);
            line = make_addr(tag_t'(5'd20 + r_tag[1:0]), {6'h15, r_idx[1:0]}, r_word[1:0]);
            run_req(line, r_op[0], r_data[15:0]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t addr,
    input  word_t data_in,
    input  logic  rd,
    input  logic  wr,
    output word_t data_out,
    output logic  done,
    output logic  stall,
    output logic  cache_hit
);

    logic [1:0] way_en;
    index_t     index;
    offset_t    offset;
    tag_t       tag_in;
    word_t      word_in;
    logic       comp, write, valid_in, sel_way, flip_victim;
    logic       hit_0, hit_1, dirty_0, dirty_1, valid_0, valid_1;
    tag_t       tag_0, tag_1, tag_out_final;
    word_t      word_0, word_1, word_out_final;
    logic       hit_final, fill_way, victim_dirty;
    addr_t      mem_addr;
    word_t      mem_wdata, mem_rdata;
    logic       write_mem, read_mem;

    cache_controller u_ctrl (
        .clk, .rst_n, .addr, .data_in, .rd, .wr,
        .hit_final, .fill_way, .victim_dirty, .tag_out_final, .word_out_final, .mem_rdata,
        .way_en, .index, .offset, .tag_in, .word_in, .comp, .write, .valid_in,
        .sel_way, .flip_victim, .mem_addr, .mem_wdata, .write_mem, .read_mem,
        .data_out, .done, .stall, .cache_hit
    );

    cache_way way_0 (
        .clk, .rst_n, .enable(way_en[0]), .index, .offset, .tag_in, .word_in,
        .comp, .write, .valid_in,
        .hit(hit_0), .dirty(dirty_0), .valid(valid_0), .tag_out(tag_0), .word_out(word_0)
    );

    cache_way way_1 (
        .clk, .rst_n, .enable(way_en[1]), .index, .offset, .tag_in, .word_in,
        .comp, .write, .valid_in,
        .hit(hit_1), .dirty(dirty_1), .valid(valid_1), .tag_out(tag_1), .word_out(word_1)
    );

    way_select u_sel (
        .clk, .rst_n, .hit_0, .hit_1, .valid_0, .valid_1, .dirty_0, .dirty_1,
        .tag_0, .tag_1, .word_0, .word_1, .sel_way, .flip_victim,
        .hit_final, .fill_way, .victim_dirty, .tag_out_final, .word_out_final
    );

    main_memory u_mem (
        .clk, .rst_n, .mem_addr, .mem_wdata, .write_mem, .read_mem, .mem_rdata
    );

endmodule

`default_nettype wire

/* cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_way
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  index_t  index,
    input  offset_t offset,
    input  tag_t    tag_in,
    input  word_t   word_in,
    input  logic    comp,
    input  logic    write,
    input  logic    valid_in,
    output logic    hit,
    output logic    dirty,
    output logic    valid,
    output tag_t    tag_out,
    output word_t   word_out
);

    localparam int SETS = 1 << `CACHE_IDX_W;

    tag_t                    tag_mem  [SETS];
    word_t                   data_mem [SETS][`CACHE_WORDS];
    logic [SETS-1:0]         valid_q;
    logic [SETS-1:0]         dirty_q;
    logic [`CACHE_OFS_W-2:0] word_sel;
    logic                    tag_match;
    logic                    wr_hit;
    logic                    wr_fill;

    assign word_sel  = offset[`CACHE_OFS_W-1:1];  // word within the line.
    assign tag_out   = tag_mem[index];
    assign word_out  = data_mem[index][word_sel];
    assign valid     = valid_q[index];
    assign dirty     = dirty_q[index];
    assign tag_match = (tag_out == tag_in);

    assign hit     = enable && comp && valid && tag_match;
    assign wr_hit  = hit && write;               // processor write into a resident line.
    assign wr_fill = enable && write && !comp;   // line refill from memory.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_hit) begin
            dirty_q[index] <= 1'b1;
        end else if (wr_fill) begin
            valid_q[index] <= valid_in;
            dirty_q[index] <= 1'b0;  // a refilled line matches memory.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit || wr_fill) begin
            data_mem[index][word_sel] <= word_in;
        end
        if (wr_fill) begin
            tag_mem[index] <= tag_in;
        end
    end

    // A compare write that misses must leave the addressed line exactly as it was.
    a_miss_wr_no_change: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enable && write && comp && !hit) |=>
            (valid_q[$past(index)] == $past(valid)) &&
            (dirty_q[$past(index)] == $past(dirty)) &&
            (tag_mem[$past(index)] == $past(tag_out)) &&
            (data_mem[$past(index)][$past(word_sel)] == $past(word_out))
    );

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
cache_pkg.sv
cache_way.sv
way_select.sv
cache_controller.sv
main_memory.sv
cache_top.sv
cache_tb.sv

/* main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module main_memory
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    input  logic  write_mem,
    input  logic  read_mem,
    output word_t mem_rdata
);

    localparam int ROW_W = `CACHE_ADDR_W - `CACHE_OFS_W;
    localparam int ROWS  = 1 << ROW_W;  // 8192 words per bank.

    word_t                    bank_mem [`CACHE_WORDS][ROWS];
    logic [`MEM_READ_LAT-1:0] rd_vld;
    addr_t                    rd_addr  [`MEM_READ_LAT];
    logic [`CACHE_OFS_W-2:0]  wr_bank;
    logic [`CACHE_OFS_W-2:0]  rd_bank;
    logic [ROW_W-1:0]         wr_row;
    logic [ROW_W-1:0]         rd_row;

    // consecutive words of a line sit in different banks.
    assign wr_bank = mem_addr[`CACHE_OFS_W-1:1];
    assign wr_row  = mem_addr[`CACHE_ADDR_W-1:`CACHE_OFS_W];
    assign rd_bank = rd_addr[`MEM_READ_LAT-1][`CACHE_OFS_W-1:1];
    assign rd_row  = rd_addr[`MEM_READ_LAT-1][`CACHE_ADDR_W-1:`CACHE_OFS_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < `CACHE_WORDS; b++) begin
                for (int r = 0; r < ROWS; r++) begin
                    bank_mem[b][r] <= '0;
                end
            end
        end else if (write_mem) begin
            bank_mem[wr_bank][wr_row] <= mem_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= {rd_vld[`MEM_READ_LAT-2:0], read_mem};
        end
    end

    // two reads can be in flight, one per stage.
    always_ff @(posedge clk) begin
        rd_addr[0] <= mem_addr;
        for (int i = 1; i < `MEM_READ_LAT; i++) begin
            rd_addr[i] <= rd_addr[i-1];
        end
    end

    assign mem_rdata = rd_vld[`MEM_READ_LAT-1] ? bank_mem[rd_bank][rd_row] : '0;

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(read_mem && write_mem)
    );

endmodule

`default_nettype wire

/* way_select.sv */
`timescale 1ns/1ps
`default_nettype none

module way_select
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  hit_0,
    input  logic  hit_1,
    input  logic  valid_0,
    input  logic  valid_1,
    input  logic  dirty_0,
    input  logic  dirty_1,
    input  tag_t  tag_0,
    input  tag_t  tag_1,
    input  word_t word_0,
    input  word_t word_1,
    input  logic  sel_way,
    input  logic  flip_victim,
    output logic  hit_final,
    output logic  fill_way,
    output logic  victim_dirty,
    output tag_t  tag_out_final,
    output word_t word_out_final
);

    logic victim;   // way to replace when both are valid.
    logic out_way;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim <= 1'b0;
        end else if (flip_victim) begin
            victim <= ~victim;
        end
    end

    // an empty way is always taken before the victim bit is consulted.
    always_comb begin
        if (!valid_0) begin
            fill_way = 1'b0;
        end else if (!valid_1) begin
            fill_way = 1'b1;
        end else begin
            fill_way = victim;
        end
    end

    assign victim_dirty = fill_way ? (valid_1 && dirty_1) : (valid_0 && dirty_0);
    assign hit_final    = hit_0 || hit_1;

    // the hit way wins, otherwise the way the controller is working on.
    assign out_way        = hit_0 ? 1'b0 : (hit_1 ? 1'b1 : sel_way);
    assign tag_out_final  = out_way ? tag_1 : tag_0;
    assign word_out_final = out_way ? word_1 : word_0;

    // A line lives in one way only, so both ways can never match the same address.
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hit_0 && hit_1)
    );

endmodule

`default_nettype wire
